// File: dv/pcap_replay_assert.sv
module pcap_replay_assert
  import pcap_replay_pkg::*;
(
  input logic              axi_aclk,
  input logic              rst_n,
  input logic              wb_ack,
  input logic [DATA_W-1:0] m_axis_tdata,
  input logic              m_axis_tvalid,
  input logic              m_axis_tready,
  input logic              m_axis_tlast,
  input logic              s_axis_tready,
  input logic              busy
);

  int assert_errors;

  // Single-cycle ack per access
  ack_one_cycle: assert property (@(posedge axi_aclk) disable iff (!rst_n)
    wb_ack |=> !wb_ack)
    else begin
      $error("wb_ack held for more than one cycle");
      assert_errors = assert_errors + 1;
    end

  // Output word held while stalled
  out_stable: assert property (@(posedge axi_aclk) disable iff (!rst_n)
    m_axis_tvalid && !m_axis_tready |=>
      m_axis_tvalid && $stable(m_axis_tdata) && $stable(m_axis_tlast))
    else begin
      $error("m_axis word changed while stalled");
      assert_errors = assert_errors + 1;
    end

  capture_blocked: assert property (@(posedge axi_aclk) disable iff (!rst_n)
    busy |-> !s_axis_tready)
    else begin
      $error("s_axis_tready high during replay");
      assert_errors = assert_errors + 1;
    end

endmodule

bind pcap_replay_top pcap_replay_assert u_assert (
  .axi_aclk      (axi_aclk),
  .rst_n         (rst_n),
  .wb_ack        (wb_ack),
  .m_axis_tdata  (m_axis_tdata),
  .m_axis_tvalid (m_axis_tvalid),
  .m_axis_tready (m_axis_tready),
  .m_axis_tlast  (m_axis_tlast),
  .s_axis_tready (s_axis_tready),
  .busy          (busy)
);

// File: dv/tb_pcap_replay.sv
module tb_pcap_replay
  import pcap_replay_pkg::*;
;

  // About eight store fills of traffic at twelve cycles per word
  localparam int WORST_WORDS = STORE_DEPTH * 8;
  localparam int MAX_CYCLES  = WORST_WORDS * 12;

  logic                  axi_aclk;
  logic                  rst_n;
  logic                  wb_cyc;
  logic                  wb_stb;
  logic                  wb_we;
  logic [REG_ADDR_W-1:0] wb_adr;
  logic [DATA_W-1:0]     wb_dat_w;
  logic [DATA_W-1:0]     wb_dat_r;
  logic                  wb_ack;
  logic [DATA_W-1:0]     s_axis_tdata;
  logic                  s_axis_tvalid;
  logic                  s_axis_tready;
  logic                  s_axis_tlast;
  logic [DATA_W-1:0]     m_axis_tdata;
  logic                  m_axis_tvalid;
  logic                  m_axis_tready;
  logic                  m_axis_tlast;

  int          errors;
  int          checks;
  int          cycles;
  logic [31:0] lfsr_state;
  // Committed words in capture order, last flag on top
  logic [DATA_W:0] model_q[$];

  pcap_replay_top DUT (.*);

  initial begin
    axi_aclk = 1'b0;
    forever #50 axi_aclk = ~axi_aclk;
  end

  always @(posedge axi_aclk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: the run did not finish within %0d clock cycles", MAX_CYCLES);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  // Galois LFSR, one step per bit taken
  function automatic logic [31:0] lfsr_bits(input int n);
    logic [31:0] val;
    logic        out;
    val = '0;
    for (int i = 0; i < n; i++) begin
      out = lfsr_state[0];
      lfsr_state = lfsr_state >> 1;
      if (out) lfsr_state = lfsr_state ^ 32'h80200003;
      val = {val[30:0], out};
    end
    return val;
  endfunction

  // Status fields placed at their register map positions
  function automatic logic [31:0] status_word(input int words, input int pkts, input bit busy);
    logic [31:0] val;
    val        = '0;
    val[0]     = busy;
    val[14:8]  = words[6:0];
    val[23:16] = pkts[7:0];
    return val;
  endfunction

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      $display("Fail %s: got 0x%08h expected 0x%08h", name, got, exp);
      errors++;
    end
  endtask

  task automatic wb_write(input logic [REG_ADDR_W-1:0] adr, input logic [DATA_W-1:0] data);
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = 1'b1;
    wb_adr   = adr;
    wb_dat_w = data;
    @(negedge axi_aclk);
    while (!wb_ack) @(negedge axi_aclk);
    // Register updates on the edge that closes the cycle
    @(negedge axi_aclk);
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic wb_read(input logic [REG_ADDR_W-1:0] adr, output logic [DATA_W-1:0] data);
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we  = 1'b0;
    wb_adr = adr;
    @(negedge axi_aclk);
    while (!wb_ack) @(negedge axi_aclk);
    data = wb_dat_r;
    // Bus held until the edge that closes the cycle
    @(negedge axi_aclk);
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
  endtask

  // Gives up after a few cycles so a stalled input cannot hang the run
  task automatic send_word(input logic [DATA_W-1:0] data, input logic last, output bit accepted);
    int waited;
    waited        = 0;
    s_axis_tdata  = data;
    s_axis_tlast  = last;
    s_axis_tvalid = 1'b1;
    while (!s_axis_tready && waited < 8) begin
      @(negedge axi_aclk);
      waited++;
    end
    accepted = s_axis_tready;
    if (accepted) @(negedge axi_aclk);
    s_axis_tvalid = 1'b0;
  endtask

  task automatic send_packet(input int len, output int sent);
    logic [DATA_W:0]   pkt_q[$];
    logic [DATA_W-1:0] data;
    bit                accepted;
    sent     = 0;
    accepted = 1'b1;
    for (int i = 0; i < len && accepted; i++) begin
      data = lfsr_bits(DATA_W);
      send_word(data, i == len - 1, accepted);
      if (accepted) begin
        sent++;
        pkt_q.push_back({i == len - 1, data});
      end
    end
    // Only whole packets are committed
    if (sent == len) begin
      foreach (pkt_q[k]) model_q.push_back(pkt_q[k]);
    end
  endtask

  task automatic run_replay(input int count, input bit random_ready);
    logic [DATA_W:0]   exp;
    logic [DATA_W-1:0] st;
    logic [31:0]       rnd;
    int                total;
    int                idx;
    int                tries;
    total = count * model_q.size();
    idx   = 0;
    tries = 0;
    m_axis_tready = 1'b1;
    wb_write(REG_REPLAY, DATA_W'(count));
    while (idx < total) begin
      @(negedge axi_aclk);
      rnd = lfsr_bits(1);
      m_axis_tready = random_ready ? rnd[0] : 1'b1;
      if (DUT.busy && s_axis_tready) begin
        $display("Capture input was ready while a replay was running");
        errors++;
      end
      if (m_axis_tvalid && m_axis_tready) begin
        exp = model_q[idx % model_q.size()];
        check_eq("m_axis_tdata", m_axis_tdata, exp[DATA_W-1:0]);
        check_eq("m_axis_tlast", {31'd0, m_axis_tlast}, {31'd0, exp[DATA_W]});
        idx++;
      end
    end
    m_axis_tready = 1'b1;
    st = 32'd1;
    while (st[0] && tries < 16) begin
      wb_read(REG_STATUS, st);
      tries++;
    end
    if (st[0]) begin
      $display("Busy did not fall after %0d status reads", tries);
      errors++;
    end
    check_eq("status", st, status_word(model_q.size(), 2, 1'b0));
    check_eq("m_axis_tvalid", {31'd0, m_axis_tvalid}, 32'd0);
  endtask

  task automatic report_test(input string name, input int errs_before);
    $display("Test %s finished with %0d errors", name, errors - errs_before);
  endtask

  task automatic test_reset_regs();
    logic [DATA_W-1:0] rd;
    int                e0;
    e0 = errors;
    wb_read(REG_STATUS, rd);
    check_eq("status", rd, 32'd0);
    wb_write(REG_CTRL, 32'h3);
    wb_read(REG_CTRL, rd);
    check_eq("ctrl", rd, 32'h3);
    wb_write(REG_CTRL, 32'h2);
    wb_read(REG_CTRL, rd);
    check_eq("ctrl", rd, 32'h2);
    wb_read(2'd3, rd);
    check_eq("unused register", rd, 32'd0);
    report_test("reset_regs", e0);
  endtask

  task automatic test_capture_count();
    logic [DATA_W-1:0] rd;
    int                len1;
    int                len2;
    int                sent;
    int                e0;
    e0   = errors;
    len1 = 1 + int'(lfsr_bits(4));
    len2 = 1 + int'(lfsr_bits(4));
    send_packet(len1, sent);
    check_eq("words accepted", sent, len1);
    send_packet(len2, sent);
    check_eq("words accepted", sent, len2);
    wb_read(REG_STATUS, rd);
    check_eq("status", rd, status_word(len1 + len2, 2, 1'b0));
    report_test("capture_count", e0);
  endtask

  task automatic test_single_replay();
    int e0;
    e0 = errors;
    run_replay(1, 1'b0);
    report_test("single_replay", e0);
  endtask

  task automatic test_repeat_replay();
    int e0;
    e0 = errors;
    run_replay(3, 1'b1);
    report_test("repeat_replay", e0);
  endtask

  task automatic test_overflow_reset();
    logic [DATA_W-1:0] rd;
    int                used;
    int                sent;
    int                e0;
    e0   = errors;
    used = model_q.size();
    send_packet(STORE_DEPTH - used + 4, sent);
    check_eq("words accepted", sent, STORE_DEPTH - used);
    check_eq("s_axis_tready", {31'd0, s_axis_tready}, 32'd0);
    wb_read(REG_STATUS, rd);
    check_eq("status", rd, status_word(used, 2, 1'b0));
    wb_write(REG_CTRL, 32'h3);
    wb_write(REG_CTRL, 32'h2);
    model_q.delete();
    wb_read(REG_STATUS, rd);
    check_eq("status", rd, 32'd0);
    send_packet(3, sent);
    check_eq("words accepted", sent, 3);
    wb_read(REG_STATUS, rd);
    check_eq("status", rd, status_word(3, 1, 1'b0));
    report_test("overflow_reset", e0);
  endtask

  initial begin
    lfsr_state    = 32'd84989;
    rst_n         = 1'b0;
    wb_cyc        = 1'b0;
    wb_stb        = 1'b0;
    wb_we         = 1'b0;
    wb_adr        = '0;
    wb_dat_w      = '0;
    s_axis_tdata  = '0;
    s_axis_tvalid = 1'b0;
    s_axis_tlast  = 1'b0;
    m_axis_tready = 1'b0;
    repeat (3) @(negedge axi_aclk);
    rst_n = 1'b1;
    @(negedge axi_aclk);
    test_reset_regs();
    test_capture_count();
    test_single_replay();
    test_repeat_replay();
    test_overflow_reset();
    errors = errors + DUT.u_assert.assert_errors;
    $display("Checks: %0d, errors: %0d, assertion failures: %0d", checks, errors,
             DUT.u_assert.assert_errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// File: flist.f
hw/pcap_replay_pkg.sv
hw/replay_regs.sv
hw/capture_writer.sv
hw/packet_store.sv
hw/replay_engine.sv
hw/stream_tx.sv
hw/pcap_replay_top.sv
dv/pcap_replay_assert.sv
dv/tb_pcap_replay.sv

// File: hw/capture_writer.sv
module capture_writer
  import pcap_replay_pkg::*;
(
  input  logic              axi_aclk,
  input  logic              rst_n,
  input  logic              sw_rst,
  input  logic              capture_en,
  input  logic              busy,
  input  logic [DATA_W-1:0] s_axis_tdata,
  input  logic              s_axis_tvalid,
  output logic              s_axis_tready,
  input  logic              s_axis_tlast,
  output logic              wr_en,
  output logic [ADDR_W-1:0] wr_addr,
  output logic [DATA_W-1:0] wr_data,
  output logic              wr_last,
  output logic [CNT_W-1:0]  committed_words,
  output logic [PKT_W-1:0]  pkt_count
);

  logic [CNT_W-1:0] wr_ptr;
  logic             overflow;
  logic             xfer;

  assign s_axis_tready = capture_en & ~busy & ~overflow & (wr_ptr < CNT_W'(STORE_DEPTH));
  assign xfer          = s_axis_tvalid & s_axis_tready;

  // Accepted words go straight into the store
  assign wr_en   = xfer;
  assign wr_addr = wr_ptr[ADDR_W-1:0];
  assign wr_data = s_axis_tdata;
  assign wr_last = s_axis_tlast;

  always_ff @(posedge axi_aclk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr          <= '0;
      committed_words <= '0;
      pkt_count       <= '0;
      overflow        <= 1'b0;
    end else if (sw_rst) begin
      wr_ptr          <= '0;
      committed_words <= '0;
      pkt_count       <= '0;
      overflow        <= 1'b0;
    end else if (xfer) begin
      if (s_axis_tlast) begin
        wr_ptr          <= wr_ptr + 1'b1;
        committed_words <= wr_ptr + 1'b1;
        pkt_count       <= pkt_count + 1'b1;
      end else if (wr_ptr == CNT_W'(STORE_DEPTH - 1)) begin
        // Store full mid-packet, drop the partial packet and stall
        wr_ptr   <= committed_words;
        overflow <= 1'b1;
      end else begin
        wr_ptr <= wr_ptr + 1'b1;
      end
    end else if (!capture_en) begin
      // Uncommitted tail is discarded once capture stops
      wr_ptr <= committed_words;
    end
  end

endmodule

// File: hw/packet_store.sv
module packet_store
  import pcap_replay_pkg::*;
(
  input  logic              axi_aclk,
  input  logic              wr_en,
  input  logic [ADDR_W-1:0] wr_addr,
  input  logic [DATA_W-1:0] wr_data,
  input  logic              wr_last,
  input  logic              rd_en,
  input  logic [ADDR_W-1:0] rd_addr,
  output logic [DATA_W-1:0] rd_data,
  output logic              rd_last
);

  // Each entry is the data word with its last flag on top
  logic [DATA_W:0] mem [STORE_DEPTH];

  always_ff @(posedge axi_aclk) begin
    if (wr_en) begin
      mem[wr_addr] <= {wr_last, wr_data};
    end
  end

  // Registered read port, one cycle of latency
  always_ff @(posedge axi_aclk) begin
    if (rd_en) begin
      rd_data <= mem[rd_addr][DATA_W-1:0];
      rd_last <= mem[rd_addr][DATA_W];
    end
  end

endmodule

// File: hw/pcap_replay_pkg.sv
package pcap_replay_pkg;

  // Stream and Wishbone data width
  localparam int DATA_W = 32;

  // Packet store geometry
  localparam int STORE_DEPTH = 64;
  localparam int ADDR_W = 6;

  // Word count, wide enough to hold a full store
  localparam int CNT_W = 7;

  // Packet counter and replay count widths
  localparam int PKT_W = 8;
  localparam int RPT_W = 8;

  // Wishbone word address
  localparam int REG_ADDR_W = 2;

  // Register map
  typedef enum logic [REG_ADDR_W-1:0] {
    REG_CTRL   = 2'd0,
    REG_REPLAY = 2'd1,
    REG_STATUS = 2'd2
  } reg_addr_e;

  // Replay engine states
  typedef enum logic [1:0] {
    RS_IDLE,
    RS_READ,
    RS_WAIT,
    RS_NEXT
  } replay_state_e;

endpackage

// File: hw/pcap_replay_top.sv
module pcap_replay_top
  import pcap_replay_pkg::*;
(
  input  logic                  axi_aclk,
  input  logic                  rst_n,
  // Wishbone register port
  input  logic                  wb_cyc,
  input  logic                  wb_stb,
  input  logic                  wb_we,
  input  logic [REG_ADDR_W-1:0] wb_adr,
  input  logic [DATA_W-1:0]     wb_dat_w,
  output logic [DATA_W-1:0]     wb_dat_r,
  output logic                  wb_ack,
  // Capture stream
  input  logic [DATA_W-1:0]     s_axis_tdata,
  input  logic                  s_axis_tvalid,
  output logic                  s_axis_tready,
  input  logic                  s_axis_tlast,
  // Replay stream
  output logic [DATA_W-1:0]     m_axis_tdata,
  output logic                  m_axis_tvalid,
  input  logic                  m_axis_tready,
  output logic                  m_axis_tlast
);

  logic              sw_rst;
  logic              capture_en;
  logic              start;
  logic [RPT_W-1:0]  replay_count;
  logic              busy;
  logic [CNT_W-1:0]  committed_words;
  logic [PKT_W-1:0]  pkt_count;
  logic              wr_en;
  logic [ADDR_W-1:0] wr_addr;
  logic [DATA_W-1:0] wr_data;
  logic              wr_last;
  logic              rd_en;
  logic [ADDR_W-1:0] rd_addr;
  logic [DATA_W-1:0] rd_data;
  logic              rd_last;
  logic              space;
  logic              push;
  logic [DATA_W-1:0] push_data;
  logic              push_last;

  replay_regs u_regs (
    .axi_aclk        (axi_aclk),
    .rst_n           (rst_n),
    .wb_cyc          (wb_cyc),
    .wb_stb          (wb_stb),
    .wb_we           (wb_we),
    .wb_adr          (wb_adr),
    .wb_dat_w        (wb_dat_w),
    .wb_dat_r        (wb_dat_r),
    .wb_ack          (wb_ack),
    .sw_rst          (sw_rst),
    .capture_en      (capture_en),
    .start           (start),
    .replay_count    (replay_count),
    .busy            (busy),
    .committed_words (committed_words),
    .pkt_count       (pkt_count)
  );

  capture_writer u_writer (
    .axi_aclk        (axi_aclk),
    .rst_n           (rst_n),
    .sw_rst          (sw_rst),
    .capture_en      (capture_en),
    .busy            (busy),
    .s_axis_tdata    (s_axis_tdata),
    .s_axis_tvalid   (s_axis_tvalid),
    .s_axis_tready   (s_axis_tready),
    .s_axis_tlast    (s_axis_tlast),
    .wr_en           (wr_en),
    .wr_addr         (wr_addr),
    .wr_data         (wr_data),
    .wr_last         (wr_last),
    .committed_words (committed_words),
    .pkt_count       (pkt_count)
  );

  packet_store u_store (
    .axi_aclk (axi_aclk),
    .wr_en    (wr_en),
    .wr_addr  (wr_addr),
    .wr_data  (wr_data),
    .wr_last  (wr_last),
    .rd_en    (rd_en),
    .rd_addr  (rd_addr),
    .rd_data  (rd_data),
    .rd_last  (rd_last)
  );

  replay_engine u_engine (
    .axi_aclk        (axi_aclk),
    .rst_n           (rst_n),
    .sw_rst          (sw_rst),
    .start           (start),
    .replay_count    (replay_count),
    .committed_words (committed_words),
    .busy            (busy),
    .rd_en           (rd_en),
    .rd_addr         (rd_addr),
    .rd_data         (rd_data),
    .rd_last         (rd_last),
    .space           (space),
    .push            (push),
    .push_data       (push_data),
    .push_last       (push_last)
  );

  stream_tx u_tx (
    .axi_aclk      (axi_aclk),
    .rst_n         (rst_n),
    .sw_rst        (sw_rst),
    .push          (push),
    .push_data     (push_data),
    .push_last     (push_last),
    .space         (space),
    .m_axis_tdata  (m_axis_tdata),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tready (m_axis_tready),
    .m_axis_tlast  (m_axis_tlast)
  );

endmodule

// File: hw/replay_engine.sv
module replay_engine
  import pcap_replay_pkg::*;
(
  input  logic              axi_aclk,
  input  logic              rst_n,
  input  logic              sw_rst,
  input  logic              start,
  input  logic [RPT_W-1:0]  replay_count,
  input  logic [CNT_W-1:0]  committed_words,
  output logic              busy,
  output logic              rd_en,
  output logic [ADDR_W-1:0] rd_addr,
  input  logic [DATA_W-1:0] rd_data,
  input  logic              rd_last,
  input  logic              space,
  output logic              push,
  output logic [DATA_W-1:0] push_data,
  output logic              push_last
);

  replay_state_e    state;
  logic [CNT_W-1:0] rd_ptr;
  logic [RPT_W-1:0] pass_cnt;

  // Read only when the transmitter can take the word in flight
  assign rd_en   = (state == RS_READ) && space;
  assign rd_addr = rd_ptr[ADDR_W-1:0];

  // Store output is valid in the cycle after the read
  assign push      = (state == RS_WAIT);
  assign push_data = rd_data;
  assign push_last = rd_last;

  always_ff @(posedge axi_aclk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= RS_IDLE;
      rd_ptr   <= '0;
      pass_cnt <= '0;
      busy     <= 1'b0;
    end else if (sw_rst) begin
      state    <= RS_IDLE;
      rd_ptr   <= '0;
      pass_cnt <= '0;
      busy     <= 1'b0;
    end else begin
      case (state)
        RS_IDLE: begin
          // Empty store or zero count leaves the engine idle
          if (start && replay_count != '0 && committed_words != '0) begin
            busy     <= 1'b1;
            rd_ptr   <= '0;
            pass_cnt <= replay_count;
            state    <= RS_READ;
          end
        end
        RS_READ: begin
          if (space) begin
            rd_ptr <= rd_ptr + 1'b1;
            state  <= RS_WAIT;
          end
        end
        RS_WAIT: begin
          if (rd_ptr == committed_words) begin
            state <= RS_NEXT;
          end else begin
            state <= RS_READ;
          end
        end
        RS_NEXT: begin
          if (pass_cnt == RPT_W'(1)) begin
            busy  <= 1'b0;
            state <= RS_IDLE;
          end else begin
            pass_cnt <= pass_cnt - 1'b1;
            rd_ptr   <= '0;
            state    <= RS_READ;
          end
        end
        default: state <= RS_IDLE;
      endcase
    end
  end

endmodule

// File: hw/replay_regs.sv
module replay_regs
  import pcap_replay_pkg::*;
(
  input  logic                  axi_aclk,
  input  logic                  rst_n,
  input  logic                  wb_cyc,
  input  logic                  wb_stb,
  input  logic                  wb_we,
  input  logic [REG_ADDR_W-1:0] wb_adr,
  input  logic [DATA_W-1:0]     wb_dat_w,
  output logic [DATA_W-1:0]     wb_dat_r,
  output logic                  wb_ack,
  output logic                  sw_rst,
  output logic                  capture_en,
  output logic                  start,
  output logic [RPT_W-1:0]      replay_count,
  input  logic                  busy,
  input  logic [CNT_W-1:0]      committed_words,
  input  logic [PKT_W-1:0]      pkt_count
);

  logic        req;
  logic        wr_fire;
  reg_addr_e   addr;
  logic [DATA_W-1:0] rd_mux;

  assign addr    = reg_addr_e'(wb_adr);
  assign req     = wb_cyc & wb_stb & ~wb_ack;
  // Writes land on the ack cycle, master still holds the bus
  assign wr_fire = wb_cyc & wb_stb & wb_ack & wb_we;

  always_comb begin
    case (addr)
      REG_CTRL:   rd_mux = {{(DATA_W-2){1'b0}}, capture_en, sw_rst};
      REG_REPLAY: rd_mux = {{(DATA_W-RPT_W){1'b0}}, replay_count};
      REG_STATUS: rd_mux = {8'd0, pkt_count, 1'b0, committed_words, 7'd0, busy};
      default:    rd_mux = '0;
    endcase
  end

  always_ff @(posedge axi_aclk or negedge rst_n) begin
    if (!rst_n) begin
      wb_ack       <= 1'b0;
      start        <= 1'b0;
      sw_rst       <= 1'b0;
      capture_en   <= 1'b0;
      replay_count <= '0;
    end else begin
      wb_ack <= req;
      // One-cycle pulse after a replay write is acknowledged
      start  <= wr_fire && (addr == REG_REPLAY);
      if (wr_fire && addr == REG_CTRL) begin
        sw_rst     <= wb_dat_w[0];
        capture_en <= wb_dat_w[1];
      end
      if (wr_fire && addr == REG_REPLAY) begin
        replay_count <= wb_dat_w[RPT_W-1:0];
      end
    end
  end

  // Read data is sampled with the request and presented with the ack
  always_ff @(posedge axi_aclk) begin
    if (req) begin
      wb_dat_r <= rd_mux;
    end
  end

endmodule

// File: hw/stream_tx.sv
module stream_tx
  import pcap_replay_pkg::*;
(
  input  logic              axi_aclk,
  input  logic              rst_n,
  input  logic              sw_rst,
  input  logic              push,
  input  logic [DATA_W-1:0] push_data,
  input  logic              push_last,
  output logic              space,
  output logic [DATA_W-1:0] m_axis_tdata,
  output logic              m_axis_tvalid,
  input  logic              m_axis_tready,
  output logic              m_axis_tlast
);

  logic [DATA_W-1:0] buf_data [2];
  logic [1:0]        buf_last;
  logic [1:0]        count;
  logic              wr_idx;
  logic              rd_idx;
  logic              pop;

  // Both entries free, so the word still in flight has a home
  assign space = (count == 2'd0);

  assign m_axis_tvalid = (count != 2'd0);
  assign m_axis_tdata  = buf_data[rd_idx];
  assign m_axis_tlast  = buf_last[rd_idx];
  assign pop           = m_axis_tvalid & m_axis_tready;

  always_ff @(posedge axi_aclk or negedge rst_n) begin
    if (!rst_n) begin
      count  <= 2'd0;
      wr_idx <= 1'b0;
      rd_idx <= 1'b0;
    end else if (sw_rst) begin
      count  <= 2'd0;
      wr_idx <= 1'b0;
      rd_idx <= 1'b0;
    end else begin
      if (push) wr_idx <= ~wr_idx;
      if (pop) rd_idx <= ~rd_idx;
      count <= count + {1'b0, push} - {1'b0, pop};
    end
  end

  always_ff @(posedge axi_aclk) begin
    if (push) begin
      buf_data[wr_idx] <= push_data;
      buf_last[wr_idx] <= push_last;
    end
  end

endmodule

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -f flist.f --top-module tb_pcap_replay -o sim_pcap_replay \
  || { echo "Verilator build failed"; exit 1; }
./obj_dir/sim_pcap_replay +verilator+error+limit+100 > sim.log 2>&1
cat sim.log
grep -q "SIMULATION FAILED" sim.log && { echo "Run failed"; exit 1; }
grep -q "SIMULATION PASSED" sim.log || { echo "Run ended without a result"; exit 1; }
exit 0
